/* rtl/eco_pkg.sv */
// address map and register layout of the bus slice
// shared by the RTL and the testbench through eco_pkg:: names

package eco_pkg;

  // device base addresses
  localparam logic [31:0] RAM_BASE  = 32'h0000_0000;
  localparam logic [31:0] TMR0_BASE = 32'hf000_0000;
  localparam logic [31:0] TMR1_BASE = 32'hf000_1000;
  localparam logic [31:0] BIO_BASE  = 32'hf100_0000;

  // timer registers, addr[3:2]
  localparam logic [1:0] TMR_CTRL = 2'd0;
  localparam logic [1:0] TMR_DIV  = 2'd1;
  localparam logic [1:0] TMR_CNT  = 2'd2;

  // timer control bits
  localparam int TMR_CTRL_EXP = 0;
  localparam int TMR_CTRL_IEN = 1;

  // board I/O registers, addr[2]
  localparam logic BIO_LED = 1'b0;
  localparam logic BIO_SW  = 1'b1;

  // interrupt vector positions
  localparam int IRQ_TMR0 = 14;
  localparam int IRQ_TMR1 = 15;

endpackage

/* rtl/busctrl.sv */
// bus controller: decodes the master's address into one device enable
// and routes that device's read data and wait back to the master

`timescale 1ns/1ps

module busctrl #(
  parameter int unsigned RAM_AWIDTH = 10
) (
  input  logic                  clk,
  input  logic                  arst_n,
  // master
  input  logic                  en,
  input  logic                  wr,
  input  logic [31:0]           addr,
  output logic [31:0]           data_out,
  output logic                  wt,
  output logic                  bus_err,
  // ram
  output logic                  ram_en,
  output logic [RAM_AWIDTH-1:0] ram_addr,
  input  logic [31:0]           ram_data_out,
  input  logic                  ram_wt,
  // tmr0
  output logic                  tmr0_en,
  input  logic [31:0]           tmr0_data_out,
  // tmr1
  output logic                  tmr1_en,
  input  logic [31:0]           tmr1_data_out,
  // bio
  output logic                  bio_en,
  input  logic [31:0]           bio_data_out
);

  // ram covers 2**RAM_AWIDTH words from its base
  localparam logic [31:0] RAM_MASK = ~((32'h1 << (RAM_AWIDTH + 2)) - 32'h1);
  // timers and bio each own a 4 KB page
  localparam logic [31:0] PAGE_MASK = 32'hffff_f000;

  logic ram_hit;
  logic tmr0_hit;
  logic tmr1_hit;
  logic bio_hit;
  logic unmapped;
  logic [31:0] rd_data;

  assign ram_hit  = (addr & RAM_MASK) == eco_pkg::RAM_BASE;
  assign tmr0_hit = (addr & PAGE_MASK) == eco_pkg::TMR0_BASE;
  assign tmr1_hit = (addr & PAGE_MASK) == eco_pkg::TMR1_BASE;
  assign bio_hit  = (addr & PAGE_MASK) == eco_pkg::BIO_BASE;
  assign unmapped = ~(ram_hit | tmr0_hit | tmr1_hit | bio_hit);

  assign ram_en  = en & ram_hit;
  assign tmr0_en = en & tmr0_hit;
  assign tmr1_en = en & tmr1_hit;
  assign bio_en  = en & bio_hit;

  assign ram_addr = addr[RAM_AWIDTH+1:2];

  // the enables are one-hot, so a plain priority chain is enough
  always_comb begin
    rd_data = 32'h0;
    wt = 1'b0;
    if (ram_en) begin
      rd_data = ram_data_out;
      wt = ram_wt;
    end else if (tmr0_en) begin
      rd_data = tmr0_data_out;
    end else if (tmr1_en) begin
      rd_data = tmr1_data_out;
    end else if (bio_en) begin
      rd_data = bio_data_out;
    end
  end

  // read data only goes back on reads
  assign data_out = wr ? 32'h0 : rd_data;

  // flags the unmapped access that completed at the last edge
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bus_err <= 1'b0;
    end else begin
      bus_err <= en & unmapped;
    end
  end

endmodule

/* rtl/ram.sv */
// on-chip word RAM behind the bus controller
// writes finish at once, reads take one wait cycle

`timescale 1ns/1ps

module ram #(
  parameter int unsigned RAM_AWIDTH = 10
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  en,
  input  logic                  wr,
  input  logic [RAM_AWIDTH-1:0] addr,
  input  logic [31:0]           data_in,
  output logic [31:0]           data_out,
  output logic                  wt
);

  localparam int unsigned DEPTH = 2 ** RAM_AWIDTH;

  logic [31:0] mem [DEPTH];
  logic        rd_done;
  logic        rd_req;

  assign rd_req = en & ~wr;

  // wait only in the first cycle of a read
  assign wt = rd_req & ~rd_done;

  always_ff @(posedge clk) begin
    if (en && wr) begin
      mem[addr] <= data_in;
    end
    if (rd_req) begin
      data_out <= mem[addr];
    end
  end

  // marks the second cycle of a read
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_done <= 1'b0;
    end else begin
      rd_done <= rd_req & ~rd_done;
    end
  end

endmodule

/* rtl/tmr.sv */
// interval timer: counts down from the divisor, reloads and sets a
// sticky expired flag; irq while expired and enabled

`timescale 1ns/1ps

module tmr (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        en,
  input  logic        wr,
  input  logic [3:2]  addr,
  input  logic [31:0] data_in,
  output logic [31:0] data_out,
  output logic        wt,
  output logic        irq
);

  logic [31:0] divisor;
  logic [31:0] counter;
  logic        expired;
  logic        ien;
  logic        ctrl_wr;
  logic        div_wr;

  assign ctrl_wr = en & wr & (addr == eco_pkg::TMR_CTRL);
  assign div_wr  = en & wr & (addr == eco_pkg::TMR_DIV);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      divisor <= 32'h0;
      counter <= 32'h0;
      expired <= 1'b0;
      ien <= 1'b0;
    end else begin
      if (ctrl_wr) begin
        ien <= data_in[eco_pkg::TMR_CTRL_IEN];
        if (!data_in[eco_pkg::TMR_CTRL_EXP]) begin
          expired <= 1'b0;
        end
      end
      // a zero divisor stops the count
      if (div_wr) begin
        divisor <= data_in;
        counter <= data_in;
      end else if (divisor != 32'h0) begin
        if (counter == 32'h1) begin
          counter <= divisor;
          // expiry wins over a clear in the same cycle
          expired <= 1'b1;
        end else begin
          counter <= counter - 32'h1;
        end
      end
    end
  end

  always_comb begin
    data_out = 32'h0;
    case (addr)
      eco_pkg::TMR_CTRL: begin
        data_out[eco_pkg::TMR_CTRL_EXP] = expired;
        data_out[eco_pkg::TMR_CTRL_IEN] = ien;
      end
      eco_pkg::TMR_DIV: data_out = divisor;
      eco_pkg::TMR_CNT: data_out = counter;
      default: data_out = 32'h0;
    endcase
  end

  assign wt  = 1'b0;
  assign irq = expired & ien;

endmodule

/* rtl/bio.sv */
// board I/O: LED output register and synchronized switch inputs

`timescale 1ns/1ps

module bio (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        en,
  input  logic        wr,
  input  logic        addr,
  input  logic [31:0] data_in,
  output logic [31:0] data_out,
  output logic        wt,
  output logic [7:0]  led,
  input  logic [7:0]  sw
);

  logic [7:0] sw_meta;
  logic [7:0] sw_sync;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      led <= 8'h0;
      sw_meta <= 8'h0;
      sw_sync <= 8'h0;
    end else begin
      if (en && wr && addr == eco_pkg::BIO_LED) begin
        led <= data_in[7:0];
      end
      // switches are asynchronous to clk
      sw_meta <= sw;
      sw_sync <= sw_meta;
    end
  end

  assign data_out = (addr == eco_pkg::BIO_LED) ? {24'h0, led} : {24'h0, sw_sync};
  assign wt = 1'b0;

endmodule

/* rtl/eco_sys.sv */
// top of the bus slice: bus controller, RAM, two timers and board I/O
// behind one master port; timer interrupts on the irq vector

`timescale 1ns/1ps

module eco_sys #(
  parameter int unsigned RAM_AWIDTH = 10
) (
  input  logic        clk,
  input  logic        arst_n,
  // master bus
  input  logic        en,
  input  logic        wr,
  input  logic [31:0] addr,
  input  logic [31:0] data_in,
  output logic [31:0] data_out,
  output logic        wt,
  output logic        bus_err,
  // interrupts
  output logic [15:0] irq,
  // board I/O
  output logic [7:0]  led,
  input  logic [7:0]  sw
);

  // ram
  logic                  ram_en;
  logic [RAM_AWIDTH-1:0] ram_addr;
  logic [31:0]           ram_data_out;
  logic                  ram_wt;
  // tmr0
  logic                  tmr0_en;
  logic [31:0]           tmr0_data_out;
  logic                  tmr0_irq;
  // tmr1
  logic                  tmr1_en;
  logic [31:0]           tmr1_data_out;
  logic                  tmr1_irq;
  // bio
  logic                  bio_en;
  logic [31:0]           bio_data_out;

  busctrl #(.RAM_AWIDTH(RAM_AWIDTH)) busctrl1 (
    .clk(clk),
    .arst_n(arst_n),
    .en(en),
    .wr(wr),
    .addr(addr[31:0]),
    .data_out(data_out[31:0]),
    .wt(wt),
    .bus_err(bus_err),
    .ram_en(ram_en),
    .ram_addr(ram_addr),
    .ram_data_out(ram_data_out[31:0]),
    .ram_wt(ram_wt),
    .tmr0_en(tmr0_en),
    .tmr0_data_out(tmr0_data_out[31:0]),
    .tmr1_en(tmr1_en),
    .tmr1_data_out(tmr1_data_out[31:0]),
    .bio_en(bio_en),
    .bio_data_out(bio_data_out[31:0])
  );

  ram #(.RAM_AWIDTH(RAM_AWIDTH)) ram1 (
    .clk(clk),
    .arst_n(arst_n),
    .en(ram_en),
    .wr(wr),
    .addr(ram_addr),
    .data_in(data_in[31:0]),
    .data_out(ram_data_out[31:0]),
    .wt(ram_wt)
  );

  // timers and bio never wait, so their wt is left open
  tmr tmr1_0 (
    .clk(clk),
    .arst_n(arst_n),
    .en(tmr0_en),
    .wr(wr),
    .addr(addr[3:2]),
    .data_in(data_in[31:0]),
    .data_out(tmr0_data_out[31:0]),
    .wt(),
    .irq(tmr0_irq)
  );

  tmr tmr1_1 (
    .clk(clk),
    .arst_n(arst_n),
    .en(tmr1_en),
    .wr(wr),
    .addr(addr[3:2]),
    .data_in(data_in[31:0]),
    .data_out(tmr1_data_out[31:0]),
    .wt(),
    .irq(tmr1_irq)
  );

  bio bio1 (
    .clk(clk),
    .arst_n(arst_n),
    .en(bio_en),
    .wr(wr),
    .addr(addr[2]),
    .data_in(data_in[31:0]),
    .data_out(bio_data_out[31:0]),
    .wt(),
    .led(led[7:0]),
    .sw(sw[7:0])
  );

  always_comb begin
    irq = 16'h0;
    irq[eco_pkg::IRQ_TMR0] = tmr0_irq;
    irq[eco_pkg::IRQ_TMR1] = tmr1_irq;
  end

endmodule

/* verification/eco_sys_chk.sv */
// concurrent checks on the bus handshake and the timer interrupts,
// bound into eco_sys

`timescale 1ns/1ps

module eco_sys_chk (
  input logic        clk,
  input logic        arst_n,
  input logic        en,
  input logic        wr,
  input logic [31:0] addr,
  input logic [31:0] data_in,
  input logic        wt,
  input logic        bus_err,
  input logic [15:0] irq,
  input logic        ram_en
);

  int unsigned fail_count = 0;

  // enable bits as last written over the bus
  logic tmr0_ien;
  logic tmr1_ien;
  logic ctrl_wr;

  assign ctrl_wr = en && wr && addr[3:2] == eco_pkg::TMR_CTRL;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tmr0_ien <= 1'b0;
      tmr1_ien <= 1'b0;
    end else if (ctrl_wr) begin
      if ((addr >> 12) == (eco_pkg::TMR0_BASE >> 12)) begin
        tmr0_ien <= data_in[eco_pkg::TMR_CTRL_IEN];
      end
      if ((addr >> 12) == (eco_pkg::TMR1_BASE >> 12)) begin
        tmr1_ien <= data_in[eco_pkg::TMR_CTRL_IEN];
      end
    end
  end

  // only a selected device can make the master wait
  a_wt_needs_en: assert property (@(posedge clk) disable iff (!arst_n) wt |-> en)
    else begin
      fail_count++;
      $error("wt high without en");
    end

  // first cycle of a RAM read waits
  a_ram_read_waits: assert property (@(posedge clk) disable iff (!arst_n)
      (ram_en && !wr && !$past(wt)) |-> wt)
    else begin
      fail_count++;
      $error("RAM read started without a wait cycle");
    end

  // and never more than one
  a_ram_one_wait: assert property (@(posedge clk) disable iff (!arst_n)
      (ram_en && !wr && wt) |=> !wt)
    else begin
      fail_count++;
      $error("RAM read waited more than one cycle");
    end

  a_irq0_ien: assert property (@(posedge clk) disable iff (!arst_n)
      irq[eco_pkg::IRQ_TMR0] |-> tmr0_ien)
    else begin
      fail_count++;
      $error("timer 0 irq high with its enable clear");
    end

  a_irq1_ien: assert property (@(posedge clk) disable iff (!arst_n)
      irq[eco_pkg::IRQ_TMR1] |-> tmr1_ien)
    else begin
      fail_count++;
      $error("timer 1 irq high with its enable clear");
    end

  a_reset_quiet: assert property (@(posedge clk) $rose(arst_n) |-> (!bus_err && irq == 16'h0))
    else begin
      fail_count++;
      $error("bus_err or irq high right after reset");
    end

endmodule

bind eco_sys eco_sys_chk u_chk (
  .clk(clk),
  .arst_n(arst_n),
  .en(en),
  .wr(wr),
  .addr(addr),
  .data_in(data_in),
  .wt(wt),
  .bus_err(bus_err),
  .irq(irq),
  .ram_en(ram_en)
);

/* verification/eco_sys_tb.sv */
// testbench for eco_sys: drives the master bus through RAM, timer,
// board I/O and unmapped accesses and checks against a reference model

`timescale 1ns/1ps

module eco_sys_tb;

  localparam int RAM_AWIDTH = 10;
  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 10;
  localparam int RAM_TESTS = 64;
  localparam int MAX_WAIT = 4;
  localparam int MAX_DIV = 16;
  // an access takes at most 4 cycles including the idle one
  localparam int ACCESS_CYCLES = 4;
  localparam int TEST_CYCLES = RESET_CYCLES + 1
      + ACCESS_CYCLES * (2 * RAM_TESTS + 2 * 6 + 3 + 5) + 2 * 2 * MAX_DIV;
  localparam int MARGIN_CYCLES = 200;

  logic        clk;
  logic        arst_n;
  logic        en;
  logic        wr;
  logic [31:0] addr;
  logic [31:0] data_in;
  logic [31:0] data_out;
  logic        wt;
  logic        bus_err;
  logic [15:0] irq;
  logic [7:0]  led;
  logic [7:0]  sw;

  int          errors;
  int          chk_errors;
  logic [31:0] lcg_state;
  logic [31:0] ram_model [2 ** RAM_AWIDTH];
  logic [RAM_AWIDTH-1:0] ram_order [$];

  eco_sys #(.RAM_AWIDTH(RAM_AWIDTH)) u_eco_sys (
    .clk(clk),
    .arst_n(arst_n),
    .en(en),
    .wr(wr),
    .addr(addr),
    .data_in(data_in),
    .data_out(data_out),
    .wt(wt),
    .bus_err(bus_err),
    .irq(irq),
    .led(led),
    .sw(sw)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] reg_addr(input logic [31:0] base, input logic [1:0] idx);
    return base | 32'({idx, 2'b00});
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      $display("Fail %s expected %h actual %h", name, exp, got);
      errors++;
    end
  endtask

  // holds the request from a falling edge until wt is seen low
  task automatic run_access(input logic w, input logic [31:0] a, input logic [31:0] d,
      output logic [31:0] q, output int waits);
    @(negedge clk);
    en = 1'b1;
    wr = w;
    addr = a;
    data_in = d;
    waits = 0;
    #(CLK_PERIOD / 4);
    while (wt && waits < MAX_WAIT) begin
      waits++;
      @(negedge clk);
      #(CLK_PERIOD / 4);
    end
    if (wt) begin
      $display("access at %h still waiting after %0d cycles", a, waits);
      errors++;
    end
    q = data_out;
    @(posedge clk);
    @(negedge clk);
    en = 1'b0;
    wr = 1'b0;
  endtask

  task automatic write_word(input logic [31:0] a, input logic [31:0] d);
    logic [31:0] q;
    int waits;
    run_access(1'b1, a, d, q, waits);
    check_value("write wait", 32'h0, 32'(waits));
  endtask

  task automatic read_word(input logic [31:0] a, output logic [31:0] q, output int waits);
    run_access(1'b0, a, 32'h0, q, waits);
  endtask

  task automatic test_ram();
    logic [31:0] q;
    logic [31:0] d;
    logic [RAM_AWIDTH-1:0] idx;
    int waits;
    for (int i = 0; i < RAM_TESTS; i++) begin
      d = next_rand();
      idx = d[RAM_AWIDTH+7:8];
      d = next_rand();
      ram_model[idx] = d;
      ram_order.push_back(idx);
      write_word(eco_pkg::RAM_BASE | 32'({idx, 2'b00}), d);
    end
    // newest first
    while (ram_order.size() > 0) begin
      idx = ram_order.pop_back();
      read_word(eco_pkg::RAM_BASE | 32'({idx, 2'b00}), q, waits);
      check_value($sformatf("ram word %0d", idx), ram_model[idx], q);
      check_value("ram read wait", 32'h1, 32'(waits));
    end
  endtask

  task automatic test_timer(input string name, input logic [31:0] base, input int bit_pos);
    logic [31:0] q;
    logic [31:0] ien_only;
    int waits;
    int n;
    int cycles;
    ien_only = 32'h1 << eco_pkg::TMR_CTRL_IEN;
    n = 4 + int'(next_rand() % (MAX_DIV - 3));
    write_word(reg_addr(base, eco_pkg::TMR_CTRL), ien_only);
    write_word(reg_addr(base, eco_pkg::TMR_DIV), 32'(n));
    cycles = 0;
    while (!irq[bit_pos] && cycles <= 2 * n) begin
      @(negedge clk);
      cycles++;
    end
    if (!irq[bit_pos]) begin
      $display("%s irq did not rise within %0d cycles", name, 2 * n);
      errors++;
    end else begin
      assert (cycles >= n - 1 && cycles <= 2 * n) else begin
        $display("Fail %s irq delay expected %0d..%0d actual %0d", name, n - 1, 2 * n, cycles);
        errors++;
      end
    end
    check_value({name, " irq vector"}, 32'h1 << bit_pos, 32'(irq));
    read_word(reg_addr(base, eco_pkg::TMR_CTRL), q, waits);
    check_value({name, " ctrl expired"}, ien_only | (32'h1 << eco_pkg::TMR_CTRL_EXP), q);
    // stopped timer keeps the sticky flag
    write_word(reg_addr(base, eco_pkg::TMR_DIV), 32'h0);
    check_value({name, " irq sticky"}, 32'h1, 32'(irq[bit_pos]));
    write_word(reg_addr(base, eco_pkg::TMR_CTRL), ien_only);
    check_value({name, " irq cleared"}, 32'h0, 32'(irq[bit_pos]));
    read_word(reg_addr(base, eco_pkg::TMR_CTRL), q, waits);
    check_value({name, " ctrl cleared"}, ien_only, q);
    write_word(reg_addr(base, eco_pkg::TMR_CTRL), 32'h0);
  endtask

  task automatic test_bio();
    logic [31:0] q;
    logic [31:0] v;
    int waits;
    v = next_rand() & 32'hff;
    write_word(reg_addr(eco_pkg::BIO_BASE, 2'(eco_pkg::BIO_LED)), v);
    check_value("led output", v, 32'(led));
    read_word(reg_addr(eco_pkg::BIO_BASE, 2'(eco_pkg::BIO_LED)), q, waits);
    check_value("led readback", v, q);
    v = next_rand();
    sw = v[7:0];
    repeat (2) @(negedge clk);
    read_word(reg_addr(eco_pkg::BIO_BASE, 2'(eco_pkg::BIO_SW)), q, waits);
    check_value("switch readback", {24'h0, v[7:0]}, q);
  endtask

  task automatic test_unmapped();
    logic [31:0] q;
    logic [31:0] known;
    int waits;
    known = next_rand();
    write_word(eco_pkg::RAM_BASE, known);
    read_word(32'h8000_0000, q, waits);
    check_value("unmapped read data", 32'h0, q);
    check_value("unmapped read wait", 32'h0, 32'(waits));
    check_value("unmapped read bus_err", 32'h1, 32'(bus_err));
    write_word(32'h8000_0000, ~known);
    check_value("unmapped write bus_err", 32'h1, 32'(bus_err));
    read_word(eco_pkg::RAM_BASE, q, waits);
    check_value("ram after unmapped write", known, q);
    check_value("mapped bus_err", 32'h0, 32'(bus_err));
  endtask

  initial begin
    #(CLK_PERIOD * (TEST_CYCLES + MARGIN_CYCLES));
    $display("watchdog expired before the tests finished");
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    clk = 1'b0;
    arst_n = 1'b0;
    en = 1'b0;
    wr = 1'b0;
    addr = 32'h0;
    data_in = 32'h0;
    sw = 8'h0;
    errors = 0;
    lcg_state = 32'd90501;
    repeat (RESET_CYCLES) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    check_value("reset data_out", 32'h0, data_out);
    check_value("reset wt", 32'h0, 32'(wt));
    check_value("reset bus_err", 32'h0, 32'(bus_err));
    check_value("reset irq", 32'h0, 32'(irq));
    check_value("reset led", 32'h0, 32'(led));
    test_ram();
    test_timer("tmr0", eco_pkg::TMR0_BASE, eco_pkg::IRQ_TMR0);
    test_timer("tmr1", eco_pkg::TMR1_BASE, eco_pkg::IRQ_TMR1);
    test_bio();
    test_unmapped();
    repeat (2) @(negedge clk);
    chk_errors = int'(u_eco_sys.u_chk.fail_count);
    $display("errors: %0d testbench, %0d assertion", errors, chk_errors);
    if (errors == 0 && chk_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* list.f */
rtl/eco_pkg.sv
rtl/busctrl.sv
rtl/ram.sv
rtl/tmr.sv
rtl/bio.sv
rtl/eco_sys.sv
verification/eco_sys_chk.sv
verification/eco_sys_tb.sv

/* Makefile */
# Verilator build and run of the eco_sys testbench

VERILATOR ?= verilator
TOP       ?= eco_sys_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx -- "$(PASS_MSG)" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
